// File: design/core_pkg.sv
// shared widths, opcodes, ALU codes and the stage 1 to stage 2 payload, imported by the core
`default_nettype none

package core_pkg;

	localparam int xlen = 32;
	localparam int mem_words = 1024;
	localparam int mem_aw = 10;

	// base opcodes of the supported subset
	localparam logic [6:0] opc_lui = 7'b0110111;
	localparam logic [6:0] opc_op_imm = 7'b0010011;
	localparam logic [6:0] opc_op = 7'b0110011;
	localparam logic [6:0] opc_load = 7'b0000011;
	localparam logic [6:0] opc_store = 7'b0100011;
	localparam logic [6:0] opc_branch = 7'b1100011;
	localparam logic [6:0] opc_jal = 7'b1101111;
	localparam logic [6:0] opc_system = 7'b1110011;

	// addi x0, x0, 0
	localparam logic [31:0] nop_inst = 32'h0000_0013;

	typedef enum logic [2:0] {
		alu_add,
		alu_sub,
		alu_and,
		alu_or,
		alu_xor,
		alu_slt,
		alu_pass_b
	} alu_op_t;

	typedef struct packed {
		logic [xlen-1:0] pc;
		logic [4:0] rd;
		logic [4:0] rs1;
		logic [4:0] rs2;
		alu_op_t alu_op;
		logic [xlen-1:0] imm;
		logic use_imm;
		logic is_load;
		logic is_store;
		logic is_branch;
		// funct3 of the branch, 000 beq, 001 bne, 100 blt
		logic [2:0] br_funct;
		logic is_jal;
		logic writes_rd;
		logic is_halt;
		logic [xlen-1:0] rs1_val;
		logic [xlen-1:0] rs2_val;
	} decoded_t;

endpackage

`default_nettype wire

// File: design/mem_port_if.sv
// request/grant port onto the shared memory, one instance per requester
`timescale 1ns/100ps
`default_nettype none

interface mem_port_if import core_pkg::*; ();

	logic req;
	logic we;
	logic [mem_aw-1:0] addr;
	logic [xlen-1:0] wdata;
	logic gnt;
	// valid one cycle after req and gnt meet
	logic [xlen-1:0] rdata;

	modport requester (output req, we, addr, wdata, input gnt, rdata);
	modport arbiter (input req, we, addr, wdata, output gnt, rdata);

endinterface

`default_nettype wire

// File: design/regfile.sv
// integer register file read by stage 1 and written from stage 3
`timescale 1ns/100ps
`default_nettype none

module regfile import core_pkg::*; (
	input  logic clk,
	input  logic reset,
	input  logic we,
	input  logic [4:0] waddr,
	input  logic [xlen-1:0] wdata,
	input  logic [4:0] raddr_a,
	input  logic [4:0] raddr_b,
	output logic [xlen-1:0] rdata_a,
	output logic [xlen-1:0] rdata_b
);

	logic [xlen-1:0] regs [32];

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (we && waddr != 5'd0) begin
			regs[waddr] <= wdata;
		end
	end

	// x0 stays zero since it is never written
	assign rdata_a = regs[raddr_a];
	assign rdata_b = regs[raddr_b];

endmodule

`default_nettype wire

// File: design/fetch_decode.sv
// stage 1 of the core: PC, instruction fetch, decode, operand read and hazard handling
`timescale 1ns/100ps
`default_nettype none

module fetch_decode import core_pkg::*; (
	input  logic clk,
	input  logic reset,
	input  logic stall,
	input  logic branch_taken,
	input  logic [xlen-1:0] branch_target,
	input  logic ex_is_load,
	input  logic [4:0] ex_rd,
	input  logic wb_en,
	input  logic [4:0] wb_rd,
	input  logic [xlen-1:0] wb_data,
	input  logic halted,
	mem_port_if.requester fetch_port,
	output decoded_t dec,
	output logic dec_valid
);

	logic [xlen-1:0] pc;
	logic [xlen-1:0] if_pc;
	logic [xlen-1:0] fetch_addr;
	logic [xlen-1:0] rf_a;
	logic [xlen-1:0] rf_b;
	logic [31:0] inst_hold;
	logic [31:0] inst_word;
	logic [31:0] inst;
	logic if_valid;
	logic use_hold;
	logic fetch_on;
	logic bubble;
	logic accept;

	function automatic alu_op_t alu_sel(input logic [2:0] funct3, input logic sub);
		case (funct3)
			3'b000: return sub ? alu_sub : alu_add;
			3'b010: return alu_slt;
			3'b100: return alu_xor;
			3'b110: return alu_or;
			3'b111: return alu_and;
			default: return alu_add;
		endcase
	endfunction

	// redirect goes straight to the fetch address, one bubble per taken branch
	assign fetch_addr = branch_taken ? branch_target : pc;
	assign fetch_port.req = fetch_on && !halted;
	assign fetch_port.we = 1'b0;
	assign fetch_port.wdata = '0;
	assign fetch_port.addr = fetch_addr[mem_aw+1:2];

	// rdata lasts one cycle, a held instruction comes from inst_hold
	assign inst_word = use_hold ? inst_hold : fetch_port.rdata;
	assign bubble = if_valid && !branch_taken && ex_is_load && ex_rd != 5'd0 &&
		(ex_rd == inst_word[19:15] || ex_rd == inst_word[24:20]);
	assign accept = !stall && !halted && fetch_port.gnt && !bubble;
	assign dec_valid = if_valid && !bubble && !branch_taken;
	assign inst = dec_valid ? inst_word : nop_inst;

	always_ff @(posedge clk) begin
		if (reset) begin
			pc <= '0;
			if_valid <= 1'b0;
			use_hold <= 1'b0;
			fetch_on <= 1'b0;
		end else begin
			fetch_on <= 1'b1;
			if (accept) begin
				if_valid <= 1'b1;
				pc <= fetch_addr + 32'd4;
			end else if (!stall && !halted) begin
				// current instruction leaves unless a bubble holds it
				if (!bubble)
					if_valid <= 1'b0;
				pc <= fetch_addr;
			end
			use_hold <= if_valid && (stall || bubble);
		end
	end

	always_ff @(posedge clk) begin
		if (accept)
			if_pc <= fetch_addr;
		if (if_valid && (stall || bubble))
			inst_hold <= inst_word;
	end

	regfile u_regfile (
		.clk(clk),
		.reset(reset),
		.we(wb_en),
		.waddr(wb_rd),
		.wdata(wb_data),
		.raddr_a(inst[19:15]),
		.raddr_b(inst[24:20]),
		.rdata_a(rf_a),
		.rdata_b(rf_b)
	);

	always_comb begin
		dec = '0;
		dec.pc = if_pc;
		dec.rd = inst[11:7];
		dec.rs1 = inst[19:15];
		dec.rs2 = inst[24:20];
		dec.br_funct = inst[14:12];
		dec.alu_op = alu_add;
		case (inst[6:0])
			opc_lui: begin
				dec.alu_op = alu_pass_b;
				dec.imm = {inst[31:12], 12'b0};
				dec.use_imm = 1'b1;
				dec.writes_rd = 1'b1;
			end
			opc_op_imm: begin
				dec.alu_op = alu_sel(inst[14:12], 1'b0);
				dec.imm = {{20{inst[31]}}, inst[31:20]};
				dec.use_imm = 1'b1;
				dec.writes_rd = 1'b1;
			end
			opc_op: begin
				dec.alu_op = alu_sel(inst[14:12], inst[30]);
				dec.writes_rd = 1'b1;
			end
			opc_load: begin
				dec.imm = {{20{inst[31]}}, inst[31:20]};
				dec.use_imm = 1'b1;
				dec.is_load = 1'b1;
				dec.writes_rd = 1'b1;
			end
			opc_store: begin
				dec.imm = {{20{inst[31]}}, inst[31:25], inst[11:7]};
				dec.use_imm = 1'b1;
				dec.is_store = 1'b1;
			end
			opc_branch: begin
				dec.imm = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
				dec.is_branch = 1'b1;
			end
			opc_jal: begin
				dec.imm = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
				dec.is_jal = 1'b1;
				dec.writes_rd = 1'b1;
			end
			opc_system: dec.is_halt = 1'b1;
			default: dec.alu_op = alu_add;
		endcase
		if (dec.rd == 5'd0)
			dec.writes_rd = 1'b0;
		// write-back of this cycle is not yet visible in the regfile
		dec.rs1_val = (wb_en && wb_rd == dec.rs1) ? wb_data : rf_a;
		dec.rs2_val = (wb_en && wb_rd == dec.rs2) ? wb_data : rf_b;
	end

endmodule

`default_nettype wire

// File: design/execute_stage.sv
// stages 2 and 3 of the core: ALU, branch resolve, data access, write-back and halt
`timescale 1ns/100ps
`default_nettype none

module execute_stage import core_pkg::*; (
	input  logic clk,
	input  logic reset,
	input  logic run,
	input  decoded_t dec,
	input  logic dec_valid,
	input  logic fetch_req,
	input  logic fetch_gnt,
	mem_port_if.requester data_port,
	output logic branch_taken,
	output logic [xlen-1:0] branch_target,
	output logic ex_is_load,
	output logic [4:0] ex_rd,
	output logic wb_en,
	output logic [4:0] wb_rd,
	output logic [xlen-1:0] wb_data,
	output logic stall,
	output logic halted
);

	decoded_t ex;
	logic ex_valid;
	logic ex_halt;
	logic stop_seen;
	logic wb_halt;
	logic mem_done;
	logic rd_fresh;
	logic data_req;
	logic cond;
	logic [xlen-1:0] fwd_a;
	logic [xlen-1:0] fwd_b;
	logic [xlen-1:0] alu_b;
	logic [xlen-1:0] alu_out;
	logic [xlen-1:0] load_val;
	logic [xlen-1:0] ld_data;
	logic [xlen-1:0] result;

	assign fwd_a = (wb_en && wb_rd == ex.rs1) ? wb_data : ex.rs1_val;
	assign fwd_b = (wb_en && wb_rd == ex.rs2) ? wb_data : ex.rs2_val;
	assign alu_b = ex.use_imm ? ex.imm : fwd_b;

	always_comb begin
		case (ex.alu_op)
			alu_sub: alu_out = fwd_a - alu_b;
			alu_and: alu_out = fwd_a & alu_b;
			alu_or: alu_out = fwd_a | alu_b;
			alu_xor: alu_out = fwd_a ^ alu_b;
			alu_slt: alu_out = {31'b0, $signed(fwd_a) < $signed(alu_b)};
			alu_pass_b: alu_out = alu_b;
			default: alu_out = fwd_a + alu_b;
		endcase
		case (ex.br_funct)
			3'b000: cond = fwd_a == fwd_b;
			3'b001: cond = fwd_a != fwd_b;
			3'b100: cond = $signed(fwd_a) < $signed(fwd_b);
			default: cond = 1'b0;
		endcase
	end

	assign branch_taken = ex_valid && (ex.is_jal || (ex.is_branch && cond));
	assign branch_target = ex.pc + ex.imm;
	assign ex_is_load = ex_valid && ex.is_load;
	assign ex_rd = ex.rd;
	assign ex_halt = ex_valid && ex.is_halt;

	// a memory op stays outstanding through its grant cycle
	assign data_req = ex_valid && (ex.is_load || ex.is_store) && !mem_done;
	assign data_port.req = data_req;
	assign data_port.we = ex.is_store;
	assign data_port.addr = alu_out[mem_aw+1:2];
	assign data_port.wdata = fwd_b;
	assign stall = !run || (fetch_req && !fetch_gnt) || data_req;

	assign ld_data = rd_fresh ? data_port.rdata : load_val;
	assign result = ex.is_jal ? ex.pc + 32'd4 : (ex.is_load ? ld_data : alu_out);

	always_ff @(posedge clk) begin
		if (reset) begin
			ex_valid <= 1'b0;
			stop_seen <= 1'b0;
			mem_done <= 1'b0;
			rd_fresh <= 1'b0;
			wb_en <= 1'b0;
			wb_halt <= 1'b0;
			halted <= 1'b0;
		end else begin
			rd_fresh <= data_port.gnt && !data_port.we;
			mem_done <= stall && (mem_done || data_port.gnt);
			if (!stall) begin
				// nothing behind ebreak may reach the data port
				ex_valid <= dec_valid && !stop_seen && !ex_halt;
				stop_seen <= stop_seen || ex_halt;
				wb_en <= ex_valid && ex.writes_rd;
				wb_halt <= ex_halt;
			end
			if (wb_halt)
				halted <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (rd_fresh)
			load_val <= data_port.rdata;
		if (!stall) begin
			ex <= dec;
			wb_rd <= ex.rd;
			wb_data <= result;
		end
	end

endmodule

`default_nettype wire

// File: design/mem_arbiter.sv
// fixed-priority sharing of the single memory port between host, data and fetch
`timescale 1ns/100ps
`default_nettype none

module mem_arbiter import core_pkg::*; (
	input  logic clk,
	input  logic reset,
	mem_port_if.arbiter host,
	mem_port_if.arbiter data,
	mem_port_if.arbiter fetch,
	output logic mem_en,
	output logic mem_we,
	output logic [mem_aw-1:0] mem_addr,
	output logic [xlen-1:0] mem_wdata,
	input  logic [xlen-1:0] mem_rdata
);

	// one-hot owner of the read data arriving this cycle
	logic [2:0] last_gnt;

	assign host.gnt = host.req;
	assign data.gnt = data.req && !host.req;
	assign fetch.gnt = fetch.req && !host.req && !data.req;
	assign mem_en = host.req || data.req || fetch.req;

	always_comb begin
		if (host.req) begin
			mem_we = host.we;
			mem_addr = host.addr;
			mem_wdata = host.wdata;
		end else if (data.req) begin
			mem_we = data.we;
			mem_addr = data.addr;
			mem_wdata = data.wdata;
		end else begin
			mem_we = fetch.we && fetch.req;
			mem_addr = fetch.addr;
			mem_wdata = fetch.wdata;
		end
	end

	always_ff @(posedge clk) begin
		if (reset)
			last_gnt <= 3'b000;
		else
			last_gnt <= {fetch.gnt, data.gnt, host.gnt};
	end

	assign host.rdata = last_gnt[0] ? mem_rdata : '0;
	assign data.rdata = last_gnt[1] ? mem_rdata : '0;
	assign fetch.rdata = last_gnt[2] ? mem_rdata : '0;

endmodule

`default_nettype wire

// File: design/unified_mem.sv
// single-port word RAM holding program and data, read data registered one cycle
`timescale 1ns/100ps
`default_nettype none

module unified_mem import core_pkg::*; (
	input  logic clk,
	input  logic en,
	input  logic we,
	input  logic [mem_aw-1:0] addr,
	input  logic [xlen-1:0] wdata,
	output logic [xlen-1:0] rdata
);

	logic [xlen-1:0] mem [mem_words];

	// read during write returns the old word
	always_ff @(posedge clk) begin
		if (en) begin
			if (we)
				mem[addr] <= wdata;
			rdata <= mem[addr];
		end
	end

endmodule

`default_nettype wire

// File: design/core_top.sv
// top level of the pipelined core with its shared memory and host access port
`timescale 1ns/100ps
`default_nettype none

module core_top import core_pkg::*; (
	input  logic clk,
	input  logic reset,
	input  logic run,
	input  logic host_req,
	input  logic host_we,
	input  logic [mem_aw-1:0] host_addr,
	input  logic [xlen-1:0] host_wdata,
	output logic host_gnt,
	output logic [xlen-1:0] host_rdata,
	output logic halted
);

	decoded_t dec;
	logic dec_valid;
	logic stall;
	logic branch_taken;
	logic [xlen-1:0] branch_target;
	logic ex_is_load;
	logic [4:0] ex_rd;
	logic wb_en;
	logic [4:0] wb_rd;
	logic [xlen-1:0] wb_data;
	logic mem_en;
	logic mem_we;
	logic [mem_aw-1:0] mem_addr;
	logic [xlen-1:0] mem_wdata;
	logic [xlen-1:0] mem_rdata;

	mem_port_if fetch_port ();
	mem_port_if data_port ();
	mem_port_if host_port ();

	assign host_port.req = host_req;
	assign host_port.we = host_we;
	assign host_port.addr = host_addr;
	assign host_port.wdata = host_wdata;
	assign host_gnt = host_port.gnt;
	assign host_rdata = host_port.rdata;

	fetch_decode u_fetch_decode (
		.clk(clk),
		.reset(reset),
		.stall(stall),
		.branch_taken(branch_taken),
		.branch_target(branch_target),
		.ex_is_load(ex_is_load),
		.ex_rd(ex_rd),
		.wb_en(wb_en),
		.wb_rd(wb_rd),
		.wb_data(wb_data),
		.halted(halted),
		.fetch_port(fetch_port.requester),
		.dec(dec),
		.dec_valid(dec_valid)
	);

	execute_stage u_execute_stage (
		.clk(clk),
		.reset(reset),
		.run(run),
		.dec(dec),
		.dec_valid(dec_valid),
		.fetch_req(fetch_port.req),
		.fetch_gnt(fetch_port.gnt),
		.data_port(data_port.requester),
		.branch_taken(branch_taken),
		.branch_target(branch_target),
		.ex_is_load(ex_is_load),
		.ex_rd(ex_rd),
		.wb_en(wb_en),
		.wb_rd(wb_rd),
		.wb_data(wb_data),
		.stall(stall),
		.halted(halted)
	);

	mem_arbiter u_mem_arbiter (
		.clk(clk),
		.reset(reset),
		.host(host_port.arbiter),
		.data(data_port.arbiter),
		.fetch(fetch_port.arbiter),
		.mem_en(mem_en),
		.mem_we(mem_we),
		.mem_addr(mem_addr),
		.mem_wdata(mem_wdata),
		.mem_rdata(mem_rdata)
	);

	unified_mem u_unified_mem (
		.clk(clk),
		.en(mem_en),
		.we(mem_we),
		.addr(mem_addr),
		.wdata(mem_wdata),
		.rdata(mem_rdata)
	);

endmodule

`default_nettype wire

// File: verif/core_sva.sv
// assertions on memory arbitration and halt behaviour, bound into the core top level
`timescale 1ns/100ps
`default_nettype none

module core_sva import core_pkg::*; (
	input logic clk,
	input logic reset,
	// bit 0 host, bit 1 data, bit 2 fetch
	input logic [2:0] req,
	input logic [2:0] gnt,
	input logic [mem_aw-1:0] data_addr,
	input logic [mem_aw-1:0] fetch_addr,
	input logic halted
);

	one_grant: assert property (@(posedge clk) disable iff (reset) $onehot0(gnt))
		else $error("more than one port granted in a cycle");

	grant_needs_req: assert property (@(posedge clk) disable iff (reset) (gnt & ~req) == 3'b000)
		else $error("grant given to a port without a request");

	// a waiting requester keeps its address
	data_hold: assert property (@(posedge clk) disable iff (reset)
		req[1] && !gnt[1] |=> $stable(data_addr))
		else $error("data address changed while waiting for grant");

	fetch_hold: assert property (@(posedge clk) disable iff (reset)
		req[2] && !gnt[2] |=> $stable(fetch_addr))
		else $error("fetch address changed while waiting for grant");

	halt_sticky: assert property (@(posedge clk) disable iff (reset) halted |=> halted)
		else $error("halted fell without reset");

endmodule

bind core_top core_sva u_core_sva (
	.clk(clk),
	.reset(reset),
	.req({fetch_port.req, data_port.req, host_port.req}),
	.gnt({fetch_port.gnt, data_port.gnt, host_port.gnt}),
	.data_addr(data_port.addr),
	.fetch_addr(fetch_port.addr),
	.halted(halted)
);

`default_nettype wire

// File: verif/tb_core.sv
// testbench for the core: random programs run on the DUT and on an ISA model, memory compared
`timescale 1ns/100ps
`default_nettype none

module tb_core import core_pkg::*; ();

	localparam int num_programs = 8;
	localparam int prog_len = 40;
	localparam int data_base = 512;
	localparam int data_len = 32;
	localparam int cycle_limit = num_programs * (prog_len * 4 + 200);

	logic clk;
	logic reset = 1'b1;
	logic run = 1'b0;
	logic host_req = 1'b0;
	logic host_we = 1'b0;
	logic [mem_aw-1:0] host_addr = '0;
	logic [xlen-1:0] host_wdata = '0;
	logic host_gnt;
	logic [xlen-1:0] host_rdata;
	logic halted;

	int seed = 87886;
	int cycles = 0;
	logic [31:0] program_words [prog_len];
	logic [31:0] model_mem [mem_words];
	logic [31:0] model_regs [32];

	core_top u_core_top (
		.clk(clk),
		.reset(reset),
		.run(run),
		.host_req(host_req),
		.host_we(host_we),
		.host_addr(host_addr),
		.host_wdata(host_wdata),
		.host_gnt(host_gnt),
		.host_rdata(host_rdata),
		.halted(halted)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	task automatic abort_run();
		$display("=== FAIL ===");
		$fatal(1, "run stopped on first failure");
	endtask

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= cycle_limit) begin
			$display("timeout after %0d cycles, the core never halted", cycles);
			abort_run();
		end
	end

	task automatic check_equal(input logic [31:0] got, input logic [31:0] expected,
		input string what);
		if (got !== expected) begin
			$display("error at %0t ns: %s read %h, expected %h", $time, what, got, expected);
			abort_run();
		end
	endtask

	function automatic int rand_below(input int n);
		return $unsigned($random(seed)) % n;
	endfunction

	// instruction encoders, RV32I base formats
	function automatic logic [31:0] r_type(input int f7, input int rs2, input int rs1,
		input int f3, input int rd);
		return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], opc_op};
	endfunction

	function automatic logic [31:0] i_type(input int imm, input int rs1, input int f3,
		input int rd, input logic [6:0] opc);
		return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], opc};
	endfunction

	function automatic logic [31:0] s_type(input int imm, input int rs2, input int rs1);
		return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], opc_store};
	endfunction

	function automatic logic [31:0] b_type(input int imm, input int rs2, input int rs1,
		input int f3);
		return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11], opc_branch};
	endfunction

	function automatic logic [31:0] j_type(input int imm, input int rd);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], opc_jal};
	endfunction

	function automatic logic [31:0] u_type(input int imm, input int rd);
		return {imm[19:0], rd[4:0], opc_lui};
	endfunction

	// x31 holds the data base, x1..x8 are the working registers
	task automatic make_program();
		int i;
		int kind;
		int rd;
		int op;
		int f3;
		int target;
		program_words[0] = u_type(1, 31);
		program_words[1] = i_type(-2048, 31, 0, 31, opc_op_imm);
		for (i = 1; i <= 8; i++) begin
			if (rand_below(2) == 0)
				program_words[1 + i] = i_type($random(seed), 0, 0, i, opc_op_imm);
			else
				program_words[1 + i] = u_type($random(seed), i);
		end
		for (i = 10; i < 31; i++) begin
			kind = rand_below(10);
			rd = 1 + rand_below(8);
			target = i + 1 + rand_below(4);
			if (target > 31)
				target = 31;
			case (kind)
				0, 1, 2: begin
					op = rand_below(6);
					f3 = (op == 2) ? 7 : (op == 3) ? 6 : (op == 4) ? 4 : (op == 5) ? 2 : 0;
					program_words[i] = r_type((op == 1) ? 32 : 0, rand_below(9),
						rand_below(9), f3, rd);
				end
				3: program_words[i] = i_type($random(seed), rand_below(9), 0, rd, opc_op_imm);
				4: program_words[i] = u_type($random(seed), rd);
				5: program_words[i] = s_type(4 * rand_below(data_len), rand_below(9), 31);
				6: begin
					program_words[i] = i_type(4 * rand_below(data_len), 31, 2, rd, opc_load);
					// dependent use right behind the load
					if (i < 30) begin
						i++;
						program_words[i] = r_type(0, rd, rand_below(9), 0, 1 + rand_below(8));
					end
				end
				7, 8: begin
					op = rand_below(3);
					f3 = (op == 0) ? 0 : (op == 1) ? 1 : 4;
					program_words[i] = b_type(4 * (target - i), rand_below(9), rand_below(9), f3);
				end
				default: program_words[i] = j_type(4 * (target - i), rd);
			endcase
		end
		// dump x1..x8 into the last eight data words
		for (i = 1; i <= 8; i++)
			program_words[30 + i] = s_type(4 * (23 + i), i, 31);
		program_words[prog_len - 1] = 32'h0010_0073;
	endtask

	function automatic void write_reg(input logic [4:0] r, input logic [31:0] v);
		if (r != 5'd0)
			model_regs[r] = v;
	endfunction

	function automatic logic [31:0] alu_result(input logic [31:0] inst, input logic [31:0] a,
		input logic [31:0] b);
		case (inst[14:12])
			3'b000: return inst[30] ? a - b : a + b;
			3'b010: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			3'b100: return a ^ b;
			3'b110: return a | b;
			3'b111: return a & b;
			default: return '0;
		endcase
	endfunction

	// sequential ISA model on the memory copy
	task automatic run_model();
		logic [31:0] pc;
		logic [31:0] next_pc;
		logic [31:0] inst;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] imm_i;
		logic [31:0] ea;
		logic taken;
		logic done;
		int steps;
		int r;
		for (r = 0; r < 32; r++)
			model_regs[r] = '0;
		pc = '0;
		done = 1'b0;
		steps = 0;
		while (!done && steps < 1000) begin
			inst = model_mem[pc[mem_aw+1:2]];
			a = model_regs[inst[19:15]];
			b = model_regs[inst[24:20]];
			imm_i = {{20{inst[31]}}, inst[31:20]};
			next_pc = pc + 32'd4;
			case (inst[6:0])
				opc_lui: write_reg(inst[11:7], {inst[31:12], 12'b0});
				opc_op_imm: write_reg(inst[11:7], a + imm_i);
				opc_op: write_reg(inst[11:7], alu_result(inst, a, b));
				opc_load: begin
					ea = a + imm_i;
					write_reg(inst[11:7], model_mem[ea[mem_aw+1:2]]);
				end
				opc_store: begin
					ea = a + {{20{inst[31]}}, inst[31:25], inst[11:7]};
					model_mem[ea[mem_aw+1:2]] = b;
				end
				opc_branch: begin
					case (inst[14:12])
						3'b000: taken = a == b;
						3'b001: taken = a != b;
						3'b100: taken = $signed(a) < $signed(b);
						default: taken = 1'b0;
					endcase
					if (taken)
						next_pc = pc + {{19{inst[31]}}, inst[31], inst[7], inst[30:25],
							inst[11:8], 1'b0};
				end
				opc_jal: begin
					write_reg(inst[11:7], pc + 32'd4);
					next_pc = pc + {{11{inst[31]}}, inst[31], inst[19:12], inst[20],
						inst[30:21], 1'b0};
				end
				default: done = 1'b1;
			endcase
			pc = next_pc;
			steps++;
		end
		if (!done) begin
			$display("the reference model did not reach ebreak");
			abort_run();
		end
	endtask

	// host is granted in the cycle of its request, which counts on the rising edge
	task automatic wait_host_grant();
		@(negedge clk);
		check_equal({31'b0, host_gnt}, 32'd1, "host grant");
		@(posedge clk);
	endtask

	task automatic host_write(input int addr, input logic [31:0] data);
		host_req <= 1'b1;
		host_we <= 1'b1;
		host_addr <= addr[mem_aw-1:0];
		host_wdata <= data;
		wait_host_grant();
	endtask

	task automatic host_release();
		host_req <= 1'b0;
		host_we <= 1'b0;
	endtask

	task automatic host_read(input int addr, output logic [31:0] data);
		host_req <= 1'b1;
		host_we <= 1'b0;
		host_addr <= addr[mem_aw-1:0];
		wait_host_grant();
		host_req <= 1'b0;
		@(negedge clk);
		data = host_rdata;
		@(posedge clk);
	endtask

	task automatic load_memories();
		int i;
		logic [31:0] v;
		for (i = 0; i < prog_len; i++) begin
			model_mem[i] = program_words[i];
			host_write(i, program_words[i]);
		end
		for (i = 0; i < data_len; i++) begin
			v = $random(seed);
			model_mem[data_base + i] = v;
			host_write(data_base + i, v);
		end
		host_release();
	endtask

	task automatic check_data(input string phase);
		int i;
		logic [31:0] v;
		for (i = 0; i < data_len; i++) begin
			host_read(data_base + i, v);
			check_equal(v, model_mem[data_base + i],
				$sformatf("%s, data word %0d", phase, data_base + i));
		end
	endtask

	task automatic apply_reset();
		@(posedge clk);
		reset <= 1'b1;
		run <= 1'b0;
		host_req <= 1'b0;
		host_we <= 1'b0;
		repeat (2) @(posedge clk);
		reset <= 1'b0;
	endtask

	task automatic run_core();
		run <= 1'b1;
		@(negedge clk);
		while (!halted)
			@(negedge clk);
		// run stays high, the halted core must stay idle
		repeat (4) @(negedge clk);
		check_equal({31'b0, halted}, 32'd1, "halted after ebreak");
		@(posedge clk);
		run <= 1'b0;
	endtask

	initial begin
		int t;
		for (t = 0; t < num_programs; t++) begin
			apply_reset();
			make_program();
			load_memories();
			if (t == 0)
				check_data("host readback");
			run_model();
			run_core();
			check_data($sformatf("program %0d after halt", t));
		end
		$display("=== PASS ===");
		$finish;
	end

endmodule

`default_nettype wire

// File: compile.f
design/core_pkg.sv
design/mem_port_if.sv
design/regfile.sv
design/fetch_decode.sv
design/execute_stage.sv
design/mem_arbiter.sv
design/unified_mem.sv
design/core_top.sv
verif/core_sva.sv
verif/tb_core.sv

// File: Makefile
VERILATOR = verilator
VFLAGS = --binary --timing --assert
TOP = tb_core
FILELIST = compile.f
OBJ_DIR = obj_dir
LOG = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "^=== PASS ===$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
